// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hss_multiplexer
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
mux_pkg.sv
event_counter.sv
link_handshake_fsm.sv
link_tx_control.sv
frame_assembler.sv
frame_disassembler.sv
hss_multiplexer.sv
tb_hss_multiplexer.sv

// ==== event_counter.sv ====
module event_counter #(
  parameter int COUNT_LIMIT = 16
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_i,
  input  logic inc_i,
  output logic done_o
);

  // Wide enough for COUNT_LIMIT - 1
  logic [$clog2(COUNT_LIMIT)-1:0] count;
  logic                           at_last;

  assign at_last = (count == $bits(count)'(COUNT_LIMIT - 1));

  // Terminal count reached on this increment
  assign done_o = inc_i && at_last;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      count <= '0;
    end else if (inc_i) begin
      if (at_last) begin
        // Wraps by itself so the next run starts clean
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// ==== frame_assembler.sv ====
module frame_assembler
  import mux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  pkt_stream_t [NUM_CHANS-1:0] tx_pkt_i,
  output logic        [NUM_CHANS-1:0] tx_pkt_rdy_o,
  output hsl_word_t                   frame_word_o,
  output logic                        frame_vld_o,
  input  logic                        frame_rdy_i
);

  typedef enum logic {
    STEP_HEADER,
    STEP_DATA
  } frame_step_t;

  frame_step_t step_q;
  chan_idx_t   chan_q;
  chan_idx_t   last_chan_q;
  pkt_data_t   pkt_q;
  logic        pick_vld;
  chan_idx_t   pick_chan;
  chan_idx_t   scan_chan;
  logic        word_taken;
  logic        header_taken;

  ////////////////////////////////////////////////////////////
  // Round-robin channel choice
  ////////////////////////////////////////////////////////////

  // Scanned backwards so the channel right after the last served wins
  always_comb begin
    pick_vld  = 1'b0;
    pick_chan = last_chan_q;
    scan_chan = last_chan_q;
    for (int i = NUM_CHANS; i >= 1; i--) begin
      scan_chan = chan_idx_t'(last_chan_q + i);
      if (tx_pkt_i[scan_chan].vld) begin
        pick_vld  = 1'b1;
        pick_chan = scan_chan;
      end
    end
  end

  assign word_taken   = frame_vld_o && frame_rdy_i;
  assign header_taken = word_taken && (step_q == STEP_HEADER);

  // Source released as its header leaves
  always_comb begin
    tx_pkt_rdy_o         = '0;
    tx_pkt_rdy_o[chan_q] = header_taken;
  end

  ////////////////////////////////////////////////////////////
  // Frame words
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (step_q == STEP_HEADER) begin
      frame_word_o.data    = {16'h0000, {(8 - CHAN_BITS){1'b0}}, chan_q, KCHR_SOF};
      frame_word_o.charisk = K_CTRL;
    end else begin
      frame_word_o.data    = pkt_q;
      frame_word_o.charisk = K_DATA;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      frame_vld_o <= 1'b0;
      step_q      <= STEP_HEADER;
      chan_q      <= '0;
      last_chan_q <= chan_idx_t'(NUM_CHANS - 1);
    end else if (!frame_vld_o) begin
      if (pick_vld) begin
        frame_vld_o <= 1'b1;
        step_q      <= STEP_HEADER;
        chan_q      <= pick_chan;
      end
    end else if (word_taken) begin
      if (step_q == STEP_HEADER) begin
        step_q <= STEP_DATA;
      end else begin
        frame_vld_o <= 1'b0;
        step_q      <= STEP_HEADER;
        last_chan_q <= chan_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (header_taken) begin
      pkt_q <= tx_pkt_i[chan_q].data;
    end
  end

endmodule

// ==== frame_disassembler.sv ====
module frame_disassembler
  import mux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  hsl_word_t                   rx_frame_word_i,
  input  logic                        rx_frame_vld_i,
  output pkt_stream_t [NUM_CHANS-1:0] rx_pkt_o,
  input  logic        [NUM_CHANS-1:0] rx_pkt_rdy_i
);

  logic                 hdr_seen_q;
  chan_idx_t            chan_q;
  logic                 is_hdr;
  logic                 is_data;
  logic                 fill;
  logic [NUM_CHANS-1:0] hold_vld_q;
  pkt_data_t            hold_data_q [NUM_CHANS];

  assign is_hdr  = rx_frame_vld_i && (rx_frame_word_i.charisk == K_CTRL) &&
                   (rx_frame_word_i.data[7:0] == KCHR_SOF);
  assign is_data = rx_frame_vld_i && (rx_frame_word_i.charisk == K_DATA);

  // Slot must be free or draining, otherwise the packet is dropped
  assign fill = is_data && hdr_seen_q && (!hold_vld_q[chan_q] || rx_pkt_rdy_i[chan_q]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hdr_seen_q <= 1'b0;
      chan_q     <= '0;
    end else if (is_hdr) begin
      hdr_seen_q <= 1'b1;
      chan_q     <= rx_frame_word_i.data[8 +: CHAN_BITS];
    end else if (is_data) begin
      hdr_seen_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Per-channel holding registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_vld_q <= '0;
    end else begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (fill && (chan_q == chan_idx_t'(c))) begin
          hold_vld_q[c] <= 1'b1;
        end else if (rx_pkt_rdy_i[c]) begin
          hold_vld_q[c] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill) begin
      hold_data_q[chan_q] <= rx_frame_word_i.data;
    end
  end

  always_comb begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      rx_pkt_o[c].data = hold_data_q[c];
      rx_pkt_o[c].vld  = hold_vld_q[c];
    end
  end

endmodule

// ==== hss_multiplexer.sv ====
module hss_multiplexer
  import mux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Link status
  output logic                        handshake_complete_o,
  output logic                        version_mismatch_o,
  // Serial word interface
  input  hsl_word_t                   rx_word_i,
  input  logic        [1:0]           rx_loss_of_sync_i,
  output hsl_word_t                   tx_word_o,
  // Packet streams into the link
  input  pkt_stream_t [NUM_CHANS-1:0] tx_pkt_i,
  output logic        [NUM_CHANS-1:0] tx_pkt_rdy_o,
  // Packet streams out of the link
  output pkt_stream_t [NUM_CHANS-1:0] rx_pkt_o,
  input  logic        [NUM_CHANS-1:0] rx_pkt_rdy_i
);

  logic      handshake_phase;
  hsl_word_t frame_word;
  logic      frame_vld;
  logic      frame_rdy;
  hsl_word_t rx_frame_word;
  logic      rx_frame_vld;

  ////////////////////////////////////////////////////////////
  // Serial link control
  ////////////////////////////////////////////////////////////

  link_handshake_fsm u_handshake (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .rx_word_i           (rx_word_i),
    .rx_loss_of_sync_i   (rx_loss_of_sync_i),
    .handshake_phase_o   (handshake_phase),
    .handshake_complete_o(handshake_complete_o),
    .version_mismatch_o  (version_mismatch_o),
    .rx_frame_word_o     (rx_frame_word),
    .rx_frame_vld_o      (rx_frame_vld)
  );

  link_tx_control u_tx_control (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .handshake_phase_i   (handshake_phase),
    .handshake_complete_i(handshake_complete_o),
    .frame_word_i        (frame_word),
    .frame_vld_i         (frame_vld),
    .frame_rdy_o         (frame_rdy),
    .tx_word_o           (tx_word_o)
  );

  ////////////////////////////////////////////////////////////
  // Packet framing
  ////////////////////////////////////////////////////////////

  frame_assembler u_assembler (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tx_pkt_i    (tx_pkt_i),
    .tx_pkt_rdy_o(tx_pkt_rdy_o),
    .frame_word_o(frame_word),
    .frame_vld_o (frame_vld),
    .frame_rdy_i (frame_rdy)
  );

  frame_disassembler u_disassembler (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rx_frame_word_i(rx_frame_word),
    .rx_frame_vld_i (rx_frame_vld),
    .rx_pkt_o       (rx_pkt_o),
    .rx_pkt_rdy_i   (rx_pkt_rdy_i)
  );

endmodule

// ==== link_handshake_fsm.sv ====
module link_handshake_fsm
  import mux_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  hsl_word_t  rx_word_i,
  input  logic [1:0] rx_loss_of_sync_i,
  output logic       handshake_phase_o,
  output logic       handshake_complete_o,
  output logic       version_mismatch_o,
  output hsl_word_t  rx_frame_word_o,
  output logic       rx_frame_vld_o
);

  hs_state_t state_q;
  hs_state_t state_d;
  logic      is_cc;
  logic      is_hs;
  logic      is_hdr;
  logic      is_data;
  logic      hs_match;
  logic      hs_phase;
  logic      restart;
  logic      cnt_clear;
  logic      cnt_inc;
  logic      cnt_done;

  ////////////////////////////////////////////////////////////
  // Received word classification
  ////////////////////////////////////////////////////////////

  assign is_cc    = (rx_word_i.charisk == K_CC);
  assign is_hs    = (rx_word_i.charisk == K_CTRL) &&
                    (rx_word_i.data[7:0] == KCHR_COMMA) &&
                    (rx_word_i.data[15:8] == HS_MARK);
  assign is_hdr   = (rx_word_i.charisk == K_CTRL) && (rx_word_i.data[7:0] == KCHR_SOF);
  assign is_data  = (rx_word_i.charisk == K_DATA);
  assign hs_match = (rx_word_i.data[23:16] == {4'h0, PROTOCOL_VERSION});
  assign hs_phase = rx_word_i.data[24];

  // Lost sync or a remote with the wrong version
  assign restart = (|rx_loss_of_sync_i) || (is_hs && !hs_match);

  ////////////////////////////////////////////////////////////
  // Handshake counting and state
  ////////////////////////////////////////////////////////////

  always_comb begin
    cnt_inc   = 1'b0;
    cnt_clear = restart;
    // CC words are transparent, anything else breaks the run
    if (!is_hs && !is_cc) begin
      cnt_clear = 1'b1;
    end
    case (state_q)
      HS_SEARCH, HS_PHASE0: begin
        cnt_inc = is_hs && hs_match;
      end
      HS_PHASE1: begin
        cnt_inc = is_hs && hs_match && hs_phase;
        if (is_hs && hs_match && !hs_phase) begin
          cnt_clear = 1'b1;
        end
      end
      default: begin
        cnt_inc = 1'b0;
      end
    endcase
    if (restart) begin
      cnt_inc = 1'b0;
    end
  end

  event_counter #(
    .COUNT_LIMIT(NUM_HANDSHAKES)
  ) u_hs_counter (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(cnt_clear),
    .inc_i  (cnt_inc),
    .done_o (cnt_done)
  );

  always_comb begin
    state_d = state_q;
    if (restart) begin
      state_d = HS_SEARCH;
    end else begin
      case (state_q)
        HS_SEARCH, HS_PHASE0: begin
          if (cnt_done) begin
            state_d = HS_PHASE1;
          end else if (cnt_inc) begin
            state_d = HS_PHASE0;
          end
        end
        HS_PHASE1: begin
          if (cnt_done) begin
            state_d = HS_COMPLETE;
          end
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q            <= HS_SEARCH;
      version_mismatch_o <= 1'b0;
      rx_frame_vld_o     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (is_hs && !hs_match) begin
        version_mismatch_o <= 1'b1;
      end else if (is_hs && hs_match) begin
        version_mismatch_o <= 1'b0;
      end
      // Frame words pass only once the link is up
      rx_frame_vld_o <= (state_q == HS_COMPLETE) && !restart && (is_hdr || is_data);
    end
  end

  always_ff @(posedge clk_i) begin
    rx_frame_word_o <= rx_word_i;
  end

  assign handshake_phase_o    = (state_q == HS_PHASE1) || (state_q == HS_COMPLETE);
  assign handshake_complete_o = (state_q == HS_COMPLETE);

endmodule

// ==== link_tx_control.sv ====
module link_tx_control
  import mux_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      handshake_phase_i,
  input  logic      handshake_complete_i,
  input  hsl_word_t frame_word_i,
  input  logic      frame_vld_i,
  output logic      frame_rdy_o,
  output hsl_word_t tx_word_o
);

  logic      cc_due;
  hsl_word_t next_word;

  ////////////////////////////////////////////////////////////
  // Clock correction timer
  ////////////////////////////////////////////////////////////

  // Free running, also during the handshake
  event_counter #(
    .COUNT_LIMIT(CLOCK_CORRECTION_INTERVAL)
  ) u_cc_counter (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(1'b0),
    .inc_i  (1'b1),
    .done_o (cc_due)
  );

  ////////////////////////////////////////////////////////////
  // Word selection
  ////////////////////////////////////////////////////////////

  // Frames may only go out on a cycle not claimed by CC
  assign frame_rdy_o = handshake_complete_i && !cc_due;

  always_comb begin
    if (cc_due) begin
      next_word = CC_WORD;
    end else if (!handshake_complete_i) begin
      // Our version, advertising the phase we have reached
      next_word = handshake_word(handshake_phase_i);
    end else if (frame_vld_i) begin
      next_word = frame_word_i;
    end else begin
      next_word = IDLE_WORD;
    end
  end

  // Link comes out of reset offering a phase 0 handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_word_o <= handshake_word(1'b0);
    end else begin
      tx_word_o <= next_word;
    end
  end

endmodule

// ==== mux_pkg.sv ====
package mux_pkg;

  ////////////////////////////////////////////////////////////
  // Counts and widths
  ////////////////////////////////////////////////////////////

  localparam int NUM_CHANS = 8;
  localparam int CHAN_BITS = 3;
  localparam int PKT_BITS  = 32;
  localparam int HSL_BITS  = 32;
  localparam int K_BITS    = 4;
  localparam int VER_BITS  = 4;

  // Consecutive matching handshakes per phase
  localparam int NUM_HANDSHAKES = 16;

  // Cycles between two clock correction words
  localparam int CLOCK_CORRECTION_INTERVAL = 100;

  ////////////////////////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////////////////////////

  typedef logic [PKT_BITS-1:0]                 pkt_data_t;
  typedef logic [CHAN_BITS-1:0]                chan_idx_t;
  typedef logic [$clog2(NUM_HANDSHAKES)-1:0]   hs_count_t;
  typedef logic [HSL_BITS-1:0]                 hsl_data_t;
  typedef logic [K_BITS-1:0]                   charisk_t;
  typedef logic [VER_BITS-1:0]                 version_t;
  typedef logic [7:0]                          kchr_t;

  localparam version_t PROTOCOL_VERSION = 4'd2;

  ////////////////////////////////////////////////////////////
  // Word codes
  ////////////////////////////////////////////////////////////

  localparam kchr_t KCHR_COMMA = 8'hBC;
  localparam kchr_t KCHR_SOF   = 8'hFB;
  localparam kchr_t KCHR_CC    = 8'h1C;
  localparam kchr_t HS_MARK    = 8'h48;

  // Charisk patterns, one bit per byte
  localparam charisk_t K_CTRL = 4'b0001;
  localparam charisk_t K_DATA = 4'b0000;
  localparam charisk_t K_CC   = 4'b1111;

  ////////////////////////////////////////////////////////////
  // Bundles and state
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    hsl_data_t data;
    charisk_t  charisk;
  } hsl_word_t;

  typedef struct packed {
    pkt_data_t data;
    logic      vld;
  } pkt_stream_t;

  typedef enum logic [1:0] {
    HS_SEARCH,
    HS_PHASE0,
    HS_PHASE1,
    HS_COMPLETE
  } hs_state_t;

  localparam hsl_word_t CC_WORD   = '{data: {4{KCHR_CC}}, charisk: K_CC};
  localparam hsl_word_t IDLE_WORD = '{data: {24'h000000, KCHR_COMMA}, charisk: K_CTRL};

  // Handshake word: comma, mark, version byte, phase in bit 0 of byte 3
  function automatic hsl_word_t handshake_word(input logic phase);
    hsl_word_t word;
    word.data    = {7'b0000000, phase, 4'h0, PROTOCOL_VERSION, HS_MARK, KCHR_COMMA};
    word.charisk = K_CTRL;
    return word;
  endfunction

endpackage

// ==== tb_hss_multiplexer.sv ====
module tb_hss_multiplexer
  import mux_pkg::*;
();

  logic                        clk;
  logic                        rst;
  logic                        loopback;
  hsl_word_t                   tb_word;
  hsl_word_t                   rx_word;
  hsl_word_t                   tx_word;
  logic [1:0]                  rx_loss;
  logic                        handshake_complete;
  logic                        version_mismatch;
  pkt_stream_t [NUM_CHANS-1:0] tx_pkt = '0;
  logic        [NUM_CHANS-1:0] tx_pkt_rdy;
  pkt_stream_t [NUM_CHANS-1:0] rx_pkt;
  logic        [NUM_CHANS-1:0] rx_rdy;

  int seed = 33608;

  // One list per channel, read by the stream driver and the scoreboard
  pkt_data_t pkt_list [NUM_CHANS][$];
  int        send_ptr [NUM_CHANS] = '{default: 0};
  int        recv_ptr [NUM_CHANS] = '{default: 0};

  logic      fair_watch;
  chan_idx_t served_q [$];

  int   cycle_no = 0;
  int   last_cc = 0;
  logic cc_seen = 1'b0;
  int   cc_gaps_linking = 0;
  int   cc_gaps_up = 0;

  pkt_stream_t [NUM_CHANS-1:0] rx_prev = '0;
  logic        [NUM_CHANS-1:0] rx_rdy_prev = '0;

  // Loopback switch
  assign rx_word = loopback ? tx_word : tb_word;

  hss_multiplexer i_dut (
    .clk_i               (clk),
    .rst_i               (rst),
    .handshake_complete_o(handshake_complete),
    .version_mismatch_o  (version_mismatch),
    .rx_word_i           (rx_word),
    .rx_loss_of_sync_i   (rx_loss),
    .tx_word_o           (tx_word),
    .tx_pkt_i            (tx_pkt),
    .tx_pkt_rdy_o        (tx_pkt_rdy),
    .rx_pkt_o            (rx_pkt),
    .rx_pkt_rdy_i        (rx_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and word helpers
  ////////////////////////////////////////////////////////////

  task automatic check_failed(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic timed_out(input string what);
    $display("Gave up waiting: %s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopping on a timeout");
  endtask

  // Comma, mark, version byte, phase in bit 0 of byte 3
  function automatic hsl_word_t make_handshake(input logic [3:0] version, input logic phase);
    hsl_word_t w;
    w.data    = {7'd0, phase, 4'h0, version, HS_MARK, KCHR_COMMA};
    w.charisk = 4'b0001;
    return w;
  endfunction

  function automatic logic is_clock_word(input hsl_word_t w);
    return (w.charisk == 4'b1111) && (w.data == {4{KCHR_CC}});
  endfunction

  function automatic logic all_delivered();
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (recv_ptr[c] != pkt_list[c].size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Random packets on random channels with short random gaps
  task automatic queue_random(input int count);
    chan_idx_t chan;
    pkt_data_t data;
    int        gap;
    for (int i = 0; i < count; i++) begin
      chan = chan_idx_t'($random(seed));
      data = $random(seed);
      gap  = $random(seed) & 3;
      pkt_list[chan].push_back(data);
      repeat (gap) @(posedge clk);
    end
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    assert (tx_word == make_handshake(PROTOCOL_VERSION, 1'b0))
      else check_failed("tx_word_o after reset is not a phase 0 handshake");
    assert (!handshake_complete && !version_mismatch)
      else check_failed("link status outputs not low after reset");
    assert (tx_pkt_rdy == '0) else check_failed("tx_pkt_rdy_o not low after reset");
    for (int c = 0; c < NUM_CHANS; c++) begin
      assert (!rx_pkt[c].vld) else check_failed($sformatf("rx_pkt_o[%0d] valid after reset", c));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Waits, each with its own limit
  ////////////////////////////////////////////////////////////

  task automatic wait_link_up(input int limit);
    int waited;
    waited = 0;
    while (!handshake_complete) begin
      @(posedge clk);
      waited++;
      assert (!version_mismatch) else check_failed("version_mismatch_o high in loopback");
      if (waited > limit) begin
        timed_out("handshake_complete_o never rose");
      end
    end
  endtask

  task automatic wait_link_down(input int limit);
    int waited;
    waited = 0;
    while (handshake_complete) begin
      @(posedge clk);
      waited++;
      if (waited > limit) begin
        timed_out("handshake_complete_o stayed high under loss of sync");
      end
    end
  endtask

  task automatic wait_mismatch(input int limit);
    int waited;
    waited = 0;
    while (!version_mismatch) begin
      @(posedge clk);
      waited++;
      if (waited > limit) begin
        timed_out("version_mismatch_o never rose");
      end
    end
  endtask

  task automatic wait_rx_valid(input int chan, input int limit);
    int waited;
    waited = 0;
    while (!rx_pkt[chan].vld) begin
      @(posedge clk);
      waited++;
      if (waited > limit) begin
        timed_out($sformatf("no packet showed up on rx channel %0d", chan));
      end
    end
  endtask

  task automatic wait_all_delivered(input int limit);
    int waited;
    waited = 0;
    while (!all_delivered()) begin
      @(posedge clk);
      waited++;
      if (waited > limit) begin
        timed_out("queued packets were not all delivered");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stream driver and monitors
  ////////////////////////////////////////////////////////////

  // Valid holds until ready, then the next listed packet follows
  always @(posedge clk) begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (!tx_pkt[c].vld || tx_pkt_rdy[c]) begin
        if (send_ptr[c] < pkt_list[c].size()) begin
          tx_pkt[c].data <= pkt_list[c][send_ptr[c]];
          tx_pkt[c].vld  <= 1'b1;
          send_ptr[c]    <= send_ptr[c] + 1;
        end else begin
          tx_pkt[c].vld <= 1'b0;
        end
      end
    end
  end

  // Per-channel order model
  always @(posedge clk) begin
    pkt_data_t expected;
    if (!rst) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (rx_pkt[c].vld && rx_rdy[c]) begin
          assert (recv_ptr[c] < pkt_list[c].size())
            else check_failed($sformatf("unexpected packet %h on channel %0d", rx_pkt[c].data, c));
          if (recv_ptr[c] < pkt_list[c].size()) begin
            expected = pkt_list[c][recv_ptr[c]];
            assert (rx_pkt[c].data == expected)
              else check_failed($sformatf("channel %0d delivered %h, expected %h",
                                          c, rx_pkt[c].data, expected));
            recv_ptr[c] <= recv_ptr[c] + 1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (fair_watch) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (tx_pkt[c].vld && tx_pkt_rdy[c]) begin
          served_q.push_back(chan_idx_t'(c));
        end
      end
    end
  end

  // Gap between clock correction words
  always @(posedge clk) begin
    cycle_no <= cycle_no + 1;
    if (rst) begin
      cc_seen <= 1'b0;
    end else if (is_clock_word(tx_word)) begin
      if (cc_seen) begin
        assert (cycle_no - last_cc == CLOCK_CORRECTION_INTERVAL)
          else check_failed($sformatf("clock correction gap of %0d cycles", cycle_no - last_cc));
        if (handshake_complete) begin
          cc_gaps_up <= cc_gaps_up + 1;
        end else begin
          cc_gaps_linking <= cc_gaps_linking + 1;
        end
      end
      cc_seen <= 1'b1;
      last_cc <= cycle_no;
    end
  end

  // Stream rules seen from the DUT side
  always @(posedge clk) begin
    if (!rst) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        assert (!tx_pkt_rdy[c] || tx_pkt[c].vld)
          else check_failed($sformatf("tx_pkt_rdy_o[%0d] high with no packet offered", c));
        if (rx_prev[c].vld && !rx_rdy_prev[c]) begin
          assert (rx_pkt[c] == rx_prev[c])
            else check_failed($sformatf("rx_pkt_o[%0d] changed while held", c));
        end
      end
    end
    rx_prev     <= rx_pkt;
    rx_rdy_prev <= rx_rdy;
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(tx_pkt_rdy))
    else check_failed("more than one tx_pkt_rdy_o bit high");

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [NUM_CHANS-1:0] seen;
    rst        = 1'b1;
    loopback   = 1'b0;
    tb_word    = make_handshake(4'd5, 1'b0);
    rx_loss    = 2'b00;
    rx_rdy     = '1;
    fair_watch = 1'b0;

    // Remote end speaks another version
    apply_reset();
    wait_mismatch(20);
    repeat (250) begin
      @(posedge clk);
      assert (version_mismatch) else check_failed("version_mismatch_o dropped");
      assert (!handshake_complete) else check_failed("handshake completed on a bad version");
      assert (is_clock_word(tx_word) || tx_word == make_handshake(PROTOCOL_VERSION, 1'b0))
        else check_failed($sformatf("tx word %h/%b is not a phase 0 handshake",
                                    tx_word.data, tx_word.charisk));
    end

    // Loopback handshake
    loopback <= 1'b1;
    apply_reset();
    wait_link_up(400);

    queue_random(48);
    wait_all_delivered(2000);

    // All channels valid at once
    @(posedge clk);
    fair_watch <= 1'b1;
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        pkt_list[c].push_back($random(seed));
      end
    end
    wait_all_delivered(1000);
    fair_watch <= 1'b0;
    assert (served_q.size() == 2 * NUM_CHANS)
      else check_failed($sformatf("%0d packets served, expected 16", served_q.size()));
    seen = '0;
    for (int i = 0; i < NUM_CHANS; i++) begin
      assert (!seen[served_q[i]])
        else check_failed($sformatf("channel %0d served twice in one round", served_q[i]));
      seen[served_q[i]] = 1'b1;
    end

    // Receive back-pressure on one channel
    @(posedge clk);
    rx_rdy[5] <= 1'b0;
    pkt_list[5].push_back($random(seed));
    wait_rx_valid(5, 300);
    repeat (20) @(posedge clk);
    rx_rdy[5] <= 1'b1;
    wait_all_delivered(300);

    // Loss of sync and recovery
    @(posedge clk);
    rx_loss <= 2'b10;
    wait_link_down(10);
    repeat (8) @(posedge clk);
    rx_loss <= 2'b00;
    wait_link_up(400);
    queue_random(16);
    wait_all_delivered(1000);

    assert (cc_gaps_linking > 0) else check_failed("no clock correction gap before link up");
    assert (cc_gaps_up > 0) else check_failed("no clock correction gap after link up");
    $display("TEST OK");
    $finish;
  end

endmodule
